// File: common/coherence_pkg.sv
package coherence_pkg;

  // Requests a CPU places on the bus
  typedef enum logic [1:0] {
    NONE,
    GETS,
    GETM,
    PUTM
  } bus_tx_t;

  // Message kinds carried by the crossbar
  typedef enum logic [1:0] {
    DATA,
    NODATA,
    NODATAE,
    EXCLUSIVE
  } mmsg_t;

  // Directory state per line
  // ID, SD and EORMD wait for a write-back from the old owner
  typedef enum logic [2:0] {
    MI,
    MS,
    MEORM,
    MID,
    MSD,
    MEORMD
  } mem_state_t;

endpackage

// File: common/system_pkg.sv
package system_pkg;

  // Processors sharing the memory
  localparam int NUM_CPUS = 4;

  // Line address width, gives 2**XLEN lines
  localparam int XLEN = 3;

  // Bits per cache line
  localparam int CACHELINE_SIZE = 32;

  // Width of a CPU index on the bus and in the crossbar
  localparam int CPU_ID_W = 2;

endpackage

// File: filelist.f
common/system_pkg.sv
common/coherence_pkg.sv
memory/coherence_memory.sv
verilog/bus_arbiter.sv
verilog/response_xbar.sv
verilog/coherence_top.sv
tb/coherence_tb.sv

// File: memory/coherence_memory.sv
`timescale 1ns/100ps

module coherence_memory (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    bus_valid,
  input  coherence_pkg::bus_tx_t                  bus_tx,
  input  logic [system_pkg::XLEN-1:0]             bus_addr,
  input  logic [system_pkg::CPU_ID_W-1:0]         bus_source,
  input  logic                                    wb_valid [system_pkg::NUM_CPUS],
  input  logic [system_pkg::XLEN-1:0]             wb_addr [system_pkg::NUM_CPUS],
  input  logic [system_pkg::CACHELINE_SIZE-1:0]   wb_data [system_pkg::NUM_CPUS],
  input  coherence_pkg::mmsg_t                    wb_mmsg [system_pkg::NUM_CPUS],
  output logic                                    arbiter_busy,
  output logic                                    mem_valid,
  output logic [system_pkg::CPU_ID_W-1:0]         mem_dest,
  output logic [system_pkg::XLEN-1:0]             mem_addr,
  output logic [system_pkg::CACHELINE_SIZE-1:0]   mem_data,
  output coherence_pkg::mmsg_t                    mem_mmsg
);
  import system_pkg::*;
  import coherence_pkg::*;

  logic [CACHELINE_SIZE-1:0] lines [2**XLEN];
  mem_state_t state [2**XLEN];
  mem_state_t next_state [2**XLEN];

  logic busy_reg;
  logic busy_next;

  logic  reply_valid;
  mmsg_t reply_mmsg;

  // Directory transitions, bus requests first, write-backs otherwise
  always_comb begin
    next_state = state;
    busy_next = busy_reg;
    if (bus_valid) begin
      unique case (state[bus_addr])
        MI: begin
          unique case (bus_tx)
            GETS, GETM: next_state[bus_addr] = MEORM;
            PUTM: begin
              next_state[bus_addr] = MID;
              busy_next = 1'b1;
            end
            default: ;
          endcase
        end
        MS: begin
          unique case (bus_tx)
            GETS: next_state[bus_addr] = MS;
            GETM: next_state[bus_addr] = MEORM;
            PUTM: begin
              next_state[bus_addr] = MSD;
              busy_next = 1'b1;
            end
            default: ;
          endcase
        end
        MEORM: begin
          // Owner must hand the line back before anyone else proceeds
          unique case (bus_tx)
            GETS: begin
              next_state[bus_addr] = MSD;
              busy_next = 1'b1;
            end
            GETM: next_state[bus_addr] = MEORM;
            PUTM: begin
              next_state[bus_addr] = MEORMD;
              busy_next = 1'b1;
            end
            default: ;
          endcase
        end
        // Transient lines ignore the bus
        default: ;
      endcase
    end else begin
      for (int i = 0; i < NUM_CPUS; i++) begin
        if (wb_valid[i]) begin
          unique case (state[wb_addr[i]])
            MID: begin
              next_state[wb_addr[i]] = MI;
              busy_next = 1'b0;
            end
            MSD: begin
              next_state[wb_addr[i]] = MS;
              busy_next = 1'b0;
            end
            MEORMD: begin
              next_state[wb_addr[i]] = (wb_mmsg[i] == NODATA) ? MEORM : MI;
              busy_next = 1'b0;
            end
            default: ;
          endcase
        end
      end
    end
  end

  // Memory answers only from I and S
  always_comb begin
    reply_valid = 1'b0;
    reply_mmsg = DATA;
    if (bus_valid) begin
      if (state[bus_addr] == MI && bus_tx == GETS) begin
        reply_valid = 1'b1;
        reply_mmsg = EXCLUSIVE;
      end else if (state[bus_addr] inside {MI, MS} && bus_tx inside {GETS, GETM}) begin
        reply_valid = 1'b1;
        reply_mmsg = DATA;
      end
    end
  end

  assign arbiter_busy = busy_reg | busy_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**XLEN; i++) begin
        state[i] <= MI;
      end
      busy_reg <= 1'b0;
      mem_valid <= 1'b0;
    end else begin
      state <= next_state;
      busy_reg <= busy_next;
      mem_valid <= reply_valid;
    end
  end

  // Each line starts out holding its own index
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**XLEN; i++) begin
        lines[i] <= CACHELINE_SIZE'(i);
      end
    end else if (!bus_valid) begin
      for (int i = 0; i < NUM_CPUS; i++) begin
        if (wb_valid[i] && wb_mmsg[i] == DATA &&
            state[wb_addr[i]] inside {MID, MSD, MEORMD}) begin
          lines[wb_addr[i]] <= wb_data[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    mem_dest <= bus_source;
    mem_addr <= bus_addr;
    mem_data <= lines[bus_addr];
    mem_mmsg <= reply_mmsg;
  end

endmodule

// File: tb/coherence_tb.sv
`timescale 1ns/100ps

module coherence_tb;
  import system_pkg::*;
  import coherence_pkg::*;

  localparam int RAND_TX = 150;
  // Directed part plus about ten cycles per random transaction
  localparam int WATCHDOG_CYCLES = 500 + RAND_TX * 10;

  logic                      clk;
  logic                      rst;
  logic                      req_valid [NUM_CPUS];
  bus_tx_t                   req_tx [NUM_CPUS];
  logic [XLEN-1:0]           req_addr [NUM_CPUS];
  logic                      in_valid [NUM_CPUS];
  logic [CPU_ID_W-1:0]       in_dest [NUM_CPUS];
  logic                      in_memory_flag [NUM_CPUS];
  logic [XLEN-1:0]           in_addr [NUM_CPUS];
  logic [CACHELINE_SIZE-1:0] in_data [NUM_CPUS];
  mmsg_t                     in_mmsg [NUM_CPUS];
  logic                      grant [NUM_CPUS];
  logic                      out_valid [NUM_CPUS];
  logic [XLEN-1:0]           out_addr [NUM_CPUS];
  logic [CACHELINE_SIZE-1:0] out_data [NUM_CPUS];
  mmsg_t                     out_mmsg [NUM_CPUS];

  // Reference directory and expected crossbar outputs
  mem_state_t                st [2**XLEN];
  logic [CACHELINE_SIZE-1:0] line_data [2**XLEN];
  logic                      model_busy;
  logic [CPU_ID_W-1:0]       last_grant;
  logic                      prev_req [NUM_CPUS];
  bus_tx_t                   prev_tx [NUM_CPUS];
  logic [XLEN-1:0]           prev_addr [NUM_CPUS];
  logic                      s1_valid;
  logic [CPU_ID_W-1:0]       s1_dest;
  logic [XLEN-1:0]           s1_addr;
  logic [CACHELINE_SIZE-1:0] s1_data;
  mmsg_t                     s1_mmsg;
  logic                      exp_valid [NUM_CPUS];
  logic [XLEN-1:0]           exp_addr [NUM_CPUS];
  logic [CACHELINE_SIZE-1:0] exp_data [NUM_CPUS];
  mmsg_t                     exp_mmsg [NUM_CPUS];
  logic                      grant_any;
  logic                      wb_any;
  logic                      pick_valid;
  logic [CPU_ID_W-1:0]       grant_idx;
  logic [CPU_ID_W-1:0]       pick;
  int                        grant_cnt;

  coherence_top i_coherence_top (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic stop_run(string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
    stop_run($sformatf("MISMATCH at %0t: %s got %0h expected %0h", $time, sig, got, exp));
  endtask

  function automatic mem_state_t next_line_state(mem_state_t s, bus_tx_t tx);
    case (s)
      MI: return (tx == PUTM) ? MID : MEORM;
      MS: return (tx == PUTM) ? MSD : ((tx == GETM) ? MEORM : MS);
      MEORM: return (tx == PUTM) ? MEORMD : ((tx == GETS) ? MSD : MEORM);
      default: return s;
    endcase
  endfunction

  // Grant decode and the rotating pick over last cycle's requests
  always_comb begin
    grant_any = 1'b0;
    grant_idx = '0;
    grant_cnt = 0;
    wb_any = 1'b0;
    pick_valid = 1'b0;
    pick = last_grant;
    for (int i = 0; i < NUM_CPUS; i++) begin
      if (grant[i]) begin
        grant_any = 1'b1;
        grant_idx = CPU_ID_W'(i);
        grant_cnt++;
      end
      wb_any |= i_coherence_top.wb_valid[i];
    end
    for (int i = 1; i <= NUM_CPUS; i++) begin
      if (!pick_valid && prev_req[CPU_ID_W'(last_grant + i)]) begin
        pick = CPU_ID_W'(last_grant + i);
        pick_valid = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    logic [XLEN-1:0] a;
    bus_tx_t tx;
    if (rst) begin
      for (int i = 0; i < 2**XLEN; i++) begin
        st[i] <= MI;
        line_data[i] <= CACHELINE_SIZE'(i);
      end
      model_busy <= 1'b0;
      last_grant <= CPU_ID_W'(NUM_CPUS - 1);
      s1_valid <= 1'b0;
      for (int c = 0; c < NUM_CPUS; c++) begin
        prev_req[c] <= 1'b0;
        exp_valid[c] <= 1'b0;
      end
    end else begin
      s1_valid <= 1'b0;
      for (int c = 0; c < NUM_CPUS; c++) begin
        prev_req[c] <= req_valid[c];
        prev_tx[c] <= req_tx[c];
        prev_addr[c] <= req_addr[c];
        // A memory reply takes the slot ahead of a CPU message to c
        exp_valid[c] <= s1_valid && s1_dest == CPU_ID_W'(c);
        exp_addr[c] <= s1_addr;
        exp_data[c] <= s1_data;
        exp_mmsg[c] <= s1_mmsg;
        for (int i = 0; i < NUM_CPUS; i++) begin
          if (!(s1_valid && s1_dest == CPU_ID_W'(c)) && in_valid[i] && !in_memory_flag[i] &&
              in_dest[i] == CPU_ID_W'(c)) begin
            exp_valid[c] <= 1'b1;
            exp_addr[c] <= in_addr[i];
            exp_data[c] <= in_data[i];
            exp_mmsg[c] <= in_mmsg[i];
          end
        end
        if (in_valid[c] && in_memory_flag[c]) begin
          a = in_addr[c];
          model_busy <= 1'b0;
          if (in_mmsg[c] == DATA && st[a] inside {MID, MSD, MEORMD}) begin
            line_data[a] <= in_data[c];
          end
          case (st[a])
            MID: st[a] <= MI;
            MSD: st[a] <= MS;
            MEORMD: st[a] <= (in_mmsg[c] == NODATA) ? MEORM : MI;
            default: ;
          endcase
        end
      end
      if (grant_any) begin
        a = prev_addr[grant_idx];
        tx = prev_tx[grant_idx];
        last_grant <= grant_idx;
        s1_valid <= st[a] inside {MI, MS} && tx inside {GETS, GETM};
        s1_dest <= grant_idx;
        s1_addr <= a;
        s1_data <= line_data[a];
        s1_mmsg <= (st[a] == MI && tx == GETS) ? EXCLUSIVE : DATA;
        st[a] <= next_line_state(st[a], tx);
        model_busy <= next_line_state(st[a], tx) inside {MID, MSD, MEORMD};
      end
    end
  end

  for (genvar c = 0; c < NUM_CPUS; c++) begin : g_out_chk
    assert property (@(posedge clk) disable iff (rst) out_valid[c] == exp_valid[c])
      else report_mismatch($sformatf("out_valid[%0d]", c), $sampled(out_valid[c]),
                           $sampled(exp_valid[c]));
    assert property (@(posedge clk) disable iff (rst)
                     exp_valid[c] |-> out_addr[c] == exp_addr[c])
      else report_mismatch($sformatf("out_addr[%0d]", c), $sampled(out_addr[c]),
                           $sampled(exp_addr[c]));
    assert property (@(posedge clk) disable iff (rst)
                     exp_valid[c] |-> out_data[c] == exp_data[c])
      else report_mismatch($sformatf("out_data[%0d]", c), $sampled(out_data[c]),
                           $sampled(exp_data[c]));
    assert property (@(posedge clk) disable iff (rst)
                     exp_valid[c] |-> out_mmsg[c] == exp_mmsg[c])
      else report_mismatch($sformatf("out_mmsg[%0d]", c), $sampled(out_mmsg[c]),
                           $sampled(exp_mmsg[c]));
  end

  assert property (@(posedge clk) disable iff (rst) !(model_busy && grant_any))
    else stop_run("A grant was issued while a write-back was outstanding");
  assert property (@(posedge clk) disable iff (rst) !(grant_any && wb_any))
    else stop_run("A grant coincided with a write-back arriving at memory");
  assert property (@(posedge clk) disable iff (rst)
                   grant_any |-> (grant_cnt == 1 && pick_valid && grant_idx == pick))
    else report_mismatch("grant index", $sampled(grant_idx), $sampled(pick));

  // Hold the request until the grant pulse shows up
  task automatic issue_request(int cpu, bus_tx_t tx, int addr);
    req_valid[cpu] = 1'b1;
    req_tx[cpu] = tx;
    req_addr[cpu] = XLEN'(addr);
    do begin
      @(negedge clk);
    end while (!grant[cpu]);
    req_valid[cpu] = 1'b0;
  endtask

  task automatic send_message(int src, int dest, logic to_mem, int addr,
                              logic [CACHELINE_SIZE-1:0] data, mmsg_t kind);
    in_valid[src] = 1'b1;
    in_dest[src] = CPU_ID_W'(dest);
    in_memory_flag[src] = to_mem;
    in_addr[src] = XLEN'(addr);
    in_data[src] = data;
    in_mmsg[src] = kind;
    @(negedge clk);
    in_valid[src] = 1'b0;
  endtask

  // Requester hands the line back whenever memory waits on it
  task automatic run_transaction(int cpu, bus_tx_t tx, int addr,
                                 logic [CACHELINE_SIZE-1:0] wb_word, mmsg_t wb_kind);
    issue_request(cpu, tx, addr);
    @(negedge clk);
    if (model_busy) begin
      send_message(cpu, 0, 1'b1, addr, wb_word, wb_kind);
    end
    repeat (3) @(negedge clk);
  endtask

  initial begin
    rst = 1'b1;
    for (int c = 0; c < NUM_CPUS; c++) begin
      req_valid[c] = 1'b0;
      req_tx[c] = NONE;
      req_addr[c] = '0;
      in_valid[c] = 1'b0;
      in_dest[c] = '0;
      in_memory_flag[c] = 1'b0;
      in_addr[c] = '0;
      in_data[c] = '0;
      in_mmsg[c] = DATA;
    end
    void'($urandom(32'h21bd8213));
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    for (int a = 0; a < 2**XLEN; a++) begin
      run_transaction(a % NUM_CPUS, GETS, a, '0, DATA);
    end
    // Line 0 goes shared, then modified, then a reader stalls on the owner
    run_transaction(1, GETS, 0, 32'h0000_1111, DATA);
    run_transaction(2, GETM, 0, '0, DATA);
    run_transaction(3, GETS, 0, 32'h0000_2222, DATA);
    // Line 1 written back with data, then with NODATA from EORMD
    run_transaction(1, PUTM, 1, 32'h0000_abcd, DATA);
    run_transaction(2, GETS, 1, '0, DATA);
    run_transaction(2, PUTM, 1, '0, NODATA);
    run_transaction(0, GETS, 1, 32'h0000_3333, DATA);
    fork
      run_transaction(0, GETM, 2, '0, DATA);
      run_transaction(1, PUTM, 3, 32'h0000_4444, DATA);
      run_transaction(2, GETS, 4, 32'h0000_5555, DATA);
      run_transaction(3, GETS, 5, 32'h0000_6666, DATA);
    join
    fork
      send_message(0, 2, 1'b0, 6, 32'hcafe_0001, NODATAE);
      send_message(3, 1, 1'b0, 5, 32'hcafe_0002, EXCLUSIVE);
    join
    repeat (2) @(negedge clk);
    // A stray memory-bound message holds off a waiting request
    fork
      run_transaction(2, GETS, 3, '0, DATA);
      send_message(1, 0, 1'b1, 7, 32'h0000_7777, NODATA);
    join
    for (int n = 0; n < RAND_TX; n++) begin
      run_transaction($urandom_range(NUM_CPUS - 1), bus_tx_t'($urandom_range(3, 1)),
                      $urandom_range(2**XLEN - 1), $urandom,
                      ($urandom_range(1) == 1) ? DATA : NODATA);
      if ($urandom_range(3) == 0) begin
        send_message($urandom_range(NUM_CPUS - 1), $urandom_range(NUM_CPUS - 1), 1'b0,
                     $urandom_range(2**XLEN - 1), $urandom, mmsg_t'($urandom_range(3)));
      end
    end
    repeat (4) @(negedge clk);
    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_run("Timeout: the run did not complete within the cycle limit");
  end

endmodule

// File: verilog/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            req_valid [system_pkg::NUM_CPUS],
  input  coherence_pkg::bus_tx_t          req_tx [system_pkg::NUM_CPUS],
  input  logic [system_pkg::XLEN-1:0]     req_addr [system_pkg::NUM_CPUS],
  input  logic                            arbiter_busy,
  input  logic                            wb_pending,
  output logic                            grant [system_pkg::NUM_CPUS],
  output logic                            bus_valid,
  output coherence_pkg::bus_tx_t          bus_tx,
  output logic [system_pkg::XLEN-1:0]     bus_addr,
  output logic [system_pkg::CPU_ID_W-1:0] bus_source
);
  import system_pkg::*;
  import coherence_pkg::*;

  logic [CPU_ID_W-1:0] last_grant;
  logic [CPU_ID_W-1:0] cand;
  logic [CPU_ID_W-1:0] pick;
  logic                pick_valid;
  logic                issue;

  // Walk from the CPU after the last grant and keep the first held request
  always_comb begin
    cand = last_grant;
    pick = last_grant;
    pick_valid = 1'b0;
    for (int i = 1; i <= NUM_CPUS; i++) begin
      cand = last_grant + CPU_ID_W'(i);
      if (!pick_valid && req_valid[cand]) begin
        pick = cand;
        pick_valid = 1'b1;
      end
    end
  end

  // Hold everything while memory waits or a write-back is in flight
  assign issue = pick_valid && !arbiter_busy && !wb_pending;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_grant <= CPU_ID_W'(NUM_CPUS - 1);
      bus_valid <= 1'b0;
      for (int i = 0; i < NUM_CPUS; i++) begin
        grant[i] <= 1'b0;
      end
    end else begin
      bus_valid <= issue;
      for (int i = 0; i < NUM_CPUS; i++) begin
        grant[i] <= issue && (pick == CPU_ID_W'(i));
      end
      if (issue) begin
        last_grant <= pick;
      end
    end
  end

  always_ff @(posedge clk) begin
    bus_tx <= req_tx[pick];
    bus_addr <= req_addr[pick];
    bus_source <= pick;
  end

endmodule

// File: verilog/coherence_top.sv
`timescale 1ns/100ps

module coherence_top (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  req_valid [system_pkg::NUM_CPUS],
  input  coherence_pkg::bus_tx_t                req_tx [system_pkg::NUM_CPUS],
  input  logic [system_pkg::XLEN-1:0]           req_addr [system_pkg::NUM_CPUS],
  input  logic                                  in_valid [system_pkg::NUM_CPUS],
  input  logic [system_pkg::CPU_ID_W-1:0]       in_dest [system_pkg::NUM_CPUS],
  input  logic                                  in_memory_flag [system_pkg::NUM_CPUS],
  input  logic [system_pkg::XLEN-1:0]           in_addr [system_pkg::NUM_CPUS],
  input  logic [system_pkg::CACHELINE_SIZE-1:0] in_data [system_pkg::NUM_CPUS],
  input  coherence_pkg::mmsg_t                  in_mmsg [system_pkg::NUM_CPUS],
  output logic                                  grant [system_pkg::NUM_CPUS],
  output logic                                  out_valid [system_pkg::NUM_CPUS],
  output logic [system_pkg::XLEN-1:0]           out_addr [system_pkg::NUM_CPUS],
  output logic [system_pkg::CACHELINE_SIZE-1:0] out_data [system_pkg::NUM_CPUS],
  output coherence_pkg::mmsg_t                  out_mmsg [system_pkg::NUM_CPUS]
);
  import system_pkg::*;
  import coherence_pkg::*;

  // Arbiter to memory
  logic                bus_valid;
  bus_tx_t             bus_tx;
  logic [XLEN-1:0]     bus_addr;
  logic [CPU_ID_W-1:0] bus_source;
  logic                arbiter_busy;
  logic                wb_pending;

  // Memory replies into the crossbar
  logic                      mem_valid;
  logic [CPU_ID_W-1:0]       mem_dest;
  logic [XLEN-1:0]           mem_addr;
  logic [CACHELINE_SIZE-1:0] mem_data;
  mmsg_t                     mem_mmsg;

  // Write-backs from the crossbar into memory
  logic                      wb_valid [NUM_CPUS];
  logic [XLEN-1:0]           wb_addr [NUM_CPUS];
  logic [CACHELINE_SIZE-1:0] wb_data [NUM_CPUS];
  mmsg_t                     wb_mmsg [NUM_CPUS];

  bus_arbiter i_bus_arbiter (.*);

  response_xbar i_response_xbar (.*);

  coherence_memory i_coherence_memory (.*);

endmodule

// File: verilog/response_xbar.sv
`timescale 1ns/100ps

module response_xbar (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  in_valid [system_pkg::NUM_CPUS],
  input  logic [system_pkg::CPU_ID_W-1:0]       in_dest [system_pkg::NUM_CPUS],
  input  logic                                  in_memory_flag [system_pkg::NUM_CPUS],
  input  logic [system_pkg::XLEN-1:0]           in_addr [system_pkg::NUM_CPUS],
  input  logic [system_pkg::CACHELINE_SIZE-1:0] in_data [system_pkg::NUM_CPUS],
  input  coherence_pkg::mmsg_t                  in_mmsg [system_pkg::NUM_CPUS],
  input  logic                                  mem_valid,
  input  logic [system_pkg::CPU_ID_W-1:0]       mem_dest,
  input  logic [system_pkg::XLEN-1:0]           mem_addr,
  input  logic [system_pkg::CACHELINE_SIZE-1:0] mem_data,
  input  coherence_pkg::mmsg_t                  mem_mmsg,
  output logic                                  out_valid [system_pkg::NUM_CPUS],
  output logic [system_pkg::XLEN-1:0]           out_addr [system_pkg::NUM_CPUS],
  output logic [system_pkg::CACHELINE_SIZE-1:0] out_data [system_pkg::NUM_CPUS],
  output coherence_pkg::mmsg_t                  out_mmsg [system_pkg::NUM_CPUS],
  output logic                                  wb_valid [system_pkg::NUM_CPUS],
  output logic [system_pkg::XLEN-1:0]           wb_addr [system_pkg::NUM_CPUS],
  output logic [system_pkg::CACHELINE_SIZE-1:0] wb_data [system_pkg::NUM_CPUS],
  output coherence_pkg::mmsg_t                  wb_mmsg [system_pkg::NUM_CPUS],
  output logic                                  wb_pending
);
  import system_pkg::*;
  import coherence_pkg::*;

  logic                      route_valid [NUM_CPUS];
  logic [XLEN-1:0]           route_addr [NUM_CPUS];
  logic [CACHELINE_SIZE-1:0] route_data [NUM_CPUS];
  mmsg_t                     route_mmsg [NUM_CPUS];

  // Only one source targets a CPU per cycle, so a plain mux is enough
  always_comb begin
    for (int j = 0; j < NUM_CPUS; j++) begin
      route_valid[j] = 1'b0;
      route_addr[j] = mem_addr;
      route_data[j] = mem_data;
      route_mmsg[j] = mem_mmsg;
      if (mem_valid && mem_dest == CPU_ID_W'(j)) begin
        route_valid[j] = 1'b1;
      end else begin
        for (int i = 0; i < NUM_CPUS; i++) begin
          if (in_valid[i] && !in_memory_flag[i] && in_dest[i] == CPU_ID_W'(j)) begin
            route_valid[j] = 1'b1;
            route_addr[j] = in_addr[i];
            route_data[j] = in_data[i];
            route_mmsg[j] = in_mmsg[i];
          end
        end
      end
    end
  end

  // Warns the arbiter one cycle ahead of the write-back reaching memory
  always_comb begin
    wb_pending = 1'b0;
    for (int i = 0; i < NUM_CPUS; i++) begin
      wb_pending |= in_valid[i] & in_memory_flag[i];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_CPUS; i++) begin
        out_valid[i] <= 1'b0;
        wb_valid[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < NUM_CPUS; i++) begin
        out_valid[i] <= route_valid[i];
        wb_valid[i] <= in_valid[i] & in_memory_flag[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_CPUS; i++) begin
      out_addr[i] <= route_addr[i];
      out_data[i] <= route_data[i];
      out_mmsg[i] <= route_mmsg[i];
      wb_addr[i] <= in_addr[i];
      wb_data[i] <= in_data[i];
      wb_mmsg[i] <= in_mmsg[i];
    end
  end

endmodule
